// File: design/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // opcode field slices
    typedef logic [5:0] op6_t;
    typedef logic [3:0] op4_t;
    typedef logic [1:0] op2_t;
    typedef logic [4:0] op5_t;

    localparam int nreg = 32;
    localparam reg_addr_t link_reg = 5'd1;

    // one-hot positions in alu_op_t
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // inst[31:26]
    localparam op6_t op6_alu   = 6'h00;
    localparam op6_t op6_lu12i = 6'h05;
    localparam op6_t op6_pcadd = 6'h07;
    localparam op6_t op6_mem   = 6'h0a;
    localparam op6_t op6_jirl  = 6'h13;
    localparam op6_t op6_b     = 6'h14;
    localparam op6_t op6_bl    = 6'h15;
    localparam op6_t op6_beq   = 6'h16;
    localparam op6_t op6_bne   = 6'h17;
    localparam op6_t op6_blt   = 6'h18;
    localparam op6_t op6_bge   = 6'h19;
    localparam op6_t op6_bltu  = 6'h1a;
    localparam op6_t op6_bgeu  = 6'h1b;

    // inst[25:22]
    localparam op4_t op4_3r    = 4'h0;
    localparam op4_t op4_shift = 4'h1;
    localparam op4_t op4_ld_w  = 4'h2;
    localparam op4_t op4_st_w  = 4'h6;
    localparam op4_t op4_slti  = 4'h8;
    localparam op4_t op4_sltui = 4'h9;
    localparam op4_t op4_addi  = 4'ha;
    localparam op4_t op4_andi  = 4'hd;
    localparam op4_t op4_ori   = 4'he;
    localparam op4_t op4_xori  = 4'hf;

    // inst[21:20]
    localparam op2_t op2_shift = 2'h0;
    localparam op2_t op2_3r    = 2'h1;

    // inst[19:15]
    localparam op5_t op5_add  = 5'h00;
    localparam op5_t op5_slli = 5'h01;
    localparam op5_t op5_sub  = 5'h02;
    localparam op5_t op5_slt  = 5'h04;
    localparam op5_t op5_sltu = 5'h05;
    localparam op5_t op5_nor  = 5'h08;
    localparam op5_t op5_and  = 5'h09;
    localparam op5_t op5_srli = 5'h09;
    localparam op5_t op5_or   = 5'h0a;
    localparam op5_t op5_xor  = 5'h0b;
    localparam op5_t op5_srai = 5'h11;

endpackage

// File: design/decode_if.sv
interface decode_if;
    import decode_pkg::*;

    alu_op_t   alu_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    word_t     imm;
    // branch flags
    logic      is_beq;
    logic      is_bne;
    logic      is_blt;
    logic      is_bge;
    logic      is_bltu;
    logic      is_bgeu;
    logic      is_jirl;
    logic      is_jump;
    word_t     br_offs;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    logic      need_r1;
    logic      need_r2;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      res_from_mem;
    logic      mem_we;

    modport decoder (
        output alu_op, src1_is_pc, src2_is_imm, imm,
        output is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_jirl, is_jump, br_offs,
        output rf_raddr1, rf_raddr2, need_r1, need_r2,
        output rf_we, rf_waddr, res_from_mem, mem_we
    );

    modport operand (
        input src1_is_pc, src2_is_imm, imm, rf_raddr1, rf_raddr2, need_r1, need_r2
    );

    modport branch (
        input is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_jirl, is_jump, br_offs
    );

endinterface

// File: design/inst_decoder.sv
module inst_decoder (
    input  decode_pkg::inst_t inst,
    decode_if.decoder         dec
);
    import decode_pkg::*;

    op6_t      op_31_26;
    op4_t      op_25_22;
    op2_t      op_21_20;
    op5_t      op_19_15;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    logic grp_3r;
    logic grp_shift;
    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_slti;
    logic inst_sltui;
    logic inst_andi;
    logic inst_ori;
    logic inst_xori;
    logic inst_lu12i_w;
    logic inst_pcaddu12i;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_b;
    logic inst_bl;
    logic cond_br;

    logic need_ui5;
    logic need_si12;
    logic need_ui12;
    logic need_si20;
    logic src2_is_4;
    logic src_reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    assign grp_3r    = (op_31_26 == op6_alu) && (op_25_22 == op4_3r) && (op_21_20 == op2_3r);
    assign grp_shift = (op_31_26 == op6_alu) && (op_25_22 == op4_shift)
                       && (op_21_20 == op2_shift);

    assign inst_add_w  = grp_3r && (op_19_15 == op5_add);
    assign inst_sub_w  = grp_3r && (op_19_15 == op5_sub);
    assign inst_slt    = grp_3r && (op_19_15 == op5_slt);
    assign inst_sltu   = grp_3r && (op_19_15 == op5_sltu);
    assign inst_nor    = grp_3r && (op_19_15 == op5_nor);
    assign inst_and    = grp_3r && (op_19_15 == op5_and);
    assign inst_or     = grp_3r && (op_19_15 == op5_or);
    assign inst_xor    = grp_3r && (op_19_15 == op5_xor);
    assign inst_slli_w = grp_shift && (op_19_15 == op5_slli);
    assign inst_srli_w = grp_shift && (op_19_15 == op5_srli);
    assign inst_srai_w = grp_shift && (op_19_15 == op5_srai);

    assign inst_addi_w = (op_31_26 == op6_alu) && (op_25_22 == op4_addi);
    assign inst_slti   = (op_31_26 == op6_alu) && (op_25_22 == op4_slti);
    assign inst_sltui  = (op_31_26 == op6_alu) && (op_25_22 == op4_sltui);
    assign inst_andi   = (op_31_26 == op6_alu) && (op_25_22 == op4_andi);
    assign inst_ori    = (op_31_26 == op6_alu) && (op_25_22 == op4_ori);
    assign inst_xori   = (op_31_26 == op6_alu) && (op_25_22 == op4_xori);

    // bit 25 separates the 1RI20 forms from their neighbours
    assign inst_lu12i_w   = (op_31_26 == op6_lu12i) && !inst[25];
    assign inst_pcaddu12i = (op_31_26 == op6_pcadd) && !inst[25];
    assign inst_ld_w      = (op_31_26 == op6_mem) && (op_25_22 == op4_ld_w);
    assign inst_st_w      = (op_31_26 == op6_mem) && (op_25_22 == op4_st_w);

    assign dec.is_jirl = (op_31_26 == op6_jirl);
    assign inst_b      = (op_31_26 == op6_b);
    assign inst_bl     = (op_31_26 == op6_bl);
    assign dec.is_beq  = (op_31_26 == op6_beq);
    assign dec.is_bne  = (op_31_26 == op6_bne);
    assign dec.is_blt  = (op_31_26 == op6_blt);
    assign dec.is_bge  = (op_31_26 == op6_bge);
    assign dec.is_bltu = (op_31_26 == op6_bltu);
    assign dec.is_bgeu = (op_31_26 == op6_bgeu);
    assign dec.is_jump = inst_b || inst_bl;

    assign cond_br = dec.is_beq || dec.is_bne || dec.is_blt || dec.is_bge
                     || dec.is_bltu || dec.is_bgeu;

    // jirl and bl compute the link address pc + 4 on the adder
    assign dec.alu_op[alu_add]  = inst_add_w || inst_addi_w || inst_ld_w || inst_st_w
                                  || dec.is_jirl || inst_bl || inst_pcaddu12i;
    assign dec.alu_op[alu_sub]  = inst_sub_w;
    assign dec.alu_op[alu_slt]  = inst_slt || inst_slti;
    assign dec.alu_op[alu_sltu] = inst_sltu || inst_sltui;
    assign dec.alu_op[alu_and]  = inst_and || inst_andi;
    assign dec.alu_op[alu_nor]  = inst_nor;
    assign dec.alu_op[alu_or]   = inst_or || inst_ori;
    assign dec.alu_op[alu_xor]  = inst_xor || inst_xori;
    assign dec.alu_op[alu_sll]  = inst_slli_w;
    assign dec.alu_op[alu_srl]  = inst_srli_w;
    assign dec.alu_op[alu_sra]  = inst_srai_w;
    assign dec.alu_op[alu_lui]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w || inst_srli_w || inst_srai_w;
    assign need_si12 = inst_addi_w || inst_ld_w || inst_st_w || inst_slti || inst_sltui;
    assign need_ui12 = inst_andi || inst_ori || inst_xori;
    assign need_si20 = inst_lu12i_w || inst_pcaddu12i;
    assign src2_is_4 = dec.is_jirl || inst_bl;

    always_comb begin
        if (src2_is_4) begin
            dec.imm = 32'd4;
        end else if (need_si20) begin
            dec.imm = {i20, 12'b0};
        end else if (need_si12) begin
            dec.imm = {{20{i12[11]}}, i12};
        end else if (need_ui12) begin
            dec.imm = {20'b0, i12};
        end else if (need_ui5) begin
            dec.imm = {27'b0, rk};
        end else begin
            dec.imm = '0;
        end
    end

    assign dec.br_offs = dec.is_jump ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

    assign dec.src1_is_pc  = dec.is_jirl || inst_bl || inst_pcaddu12i;
    assign dec.src2_is_imm = need_ui5 || need_si12 || need_ui12 || need_si20 || src2_is_4;

    // stores and compare branches read rd on the second port
    assign src_reg_is_rd = inst_st_w || cond_br;
    assign dec.rf_raddr1 = rj;
    assign dec.rf_raddr2 = src_reg_is_rd ? rd : rk;

    assign dec.need_r1 = grp_3r || need_ui5 || need_si12 || need_ui12 || dec.is_jirl || cond_br;
    assign dec.need_r2 = grp_3r || inst_st_w || cond_br;

    assign dec.rf_we        = (|dec.alu_op) && !inst_st_w;
    assign dec.rf_waddr     = inst_bl ? link_reg : rd;
    assign dec.res_from_mem = inst_ld_w;
    assign dec.mem_we       = inst_st_w;

    always_comb begin
        assert ($onehot0(dec.alu_op))
        else $error("alu_op has more than one bit set: %b", dec.alu_op);
    end

endmodule

// File: design/regfile.sv
module regfile (
    input  logic                  clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  decode_pkg::reg_addr_t waddr,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2,
    input  logic                  we,
    input  decode_pkg::word_t     wdata
);
    import decode_pkg::*;

    word_t rf [nreg];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: design/operand_forward.sv
module operand_forward (
    decode_if.operand             dec,
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    input  decode_pkg::word_t     pc,
    input  logic                  es_res_from_mem,
    input  logic                  es_rf_we,
    input  decode_pkg::reg_addr_t es_rf_waddr,
    input  decode_pkg::word_t     es_rf_wdata,
    input  logic                  ms_rf_we,
    input  decode_pkg::reg_addr_t ms_rf_waddr,
    input  decode_pkg::word_t     ms_rf_wdata,
    input  logic                  ws_rf_we,
    input  decode_pkg::reg_addr_t ws_rf_waddr,
    input  decode_pkg::word_t     ws_rf_wdata,
    output decode_pkg::word_t     rj_value,
    output decode_pkg::word_t     rkd_value,
    output decode_pkg::word_t     alu_src1,
    output decode_pkg::word_t     alu_src2,
    output logic                  stall
);
    import decode_pkg::*;

    logic hit1_es;
    logic hit2_es;

    function automatic logic hit(input reg_addr_t src, input logic we, input reg_addr_t waddr);
        return we && (src != '0) && (src == waddr);
    endfunction

    // newest producer wins
    function automatic word_t pick(input reg_addr_t src, input word_t rf_value);
        word_t value;
        if (hit(src, es_rf_we, es_rf_waddr)) begin
            value = es_rf_wdata;
        end else if (hit(src, ms_rf_we, ms_rf_waddr)) begin
            value = ms_rf_wdata;
        end else if (hit(src, ws_rf_we, ws_rf_waddr)) begin
            value = ws_rf_wdata;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    always_comb begin
        rj_value  = pick(dec.rf_raddr1, rf_rdata1);
        rkd_value = pick(dec.rf_raddr2, rf_rdata2);
    end

    assign alu_src1 = dec.src1_is_pc  ? pc      : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

    // a load in execute has no data yet
    assign hit1_es = hit(dec.rf_raddr1, es_rf_we, es_rf_waddr);
    assign hit2_es = hit(dec.rf_raddr2, es_rf_we, es_rf_waddr);
    assign stall   = es_res_from_mem && ((hit1_es && dec.need_r1) || (hit2_es && dec.need_r2));

    always_comb begin
        assert (!stall || (es_res_from_mem && es_rf_we && es_rf_waddr != '0))
        else $error("stall without a load writing a live register in execute");
    end

endmodule

// File: design/branch_unit.sv
module branch_unit (
    decode_if.branch          dec,
    input  decode_pkg::word_t rj_value,
    input  decode_pkg::word_t rkd_value,
    input  decode_pkg::word_t pc,
    input  logic              valid,
    output logic              taken,
    output decode_pkg::word_t target
);
    import decode_pkg::*;

    logic  rj_eq_rd;
    logic  rj_lt_rd;
    logic  rj_ltu_rd;
    logic  cond_met;
    word_t base;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    assign cond_met = (dec.is_beq  &&  rj_eq_rd)
                   || (dec.is_bne  && !rj_eq_rd)
                   || (dec.is_blt  &&  rj_lt_rd)
                   || (dec.is_bge  && !rj_lt_rd)
                   || (dec.is_bltu &&  rj_ltu_rd)
                   || (dec.is_bgeu && !rj_ltu_rd)
                   || dec.is_jirl
                   || dec.is_jump;

    assign taken = valid && cond_met;

    // jirl is register relative, everything else pc relative
    assign base   = dec.is_jirl ? rj_value : pc;
    assign target = base + dec.br_offs;

endmodule

// File: design/decode_stage.sv
module decode_stage (
    input  logic                  clk,
    input  logic                  resetn,
    // fetch
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::inst_t     fs_inst,
    input  decode_pkg::word_t     fs_pc,
    output logic                  ds_allowin,
    // execute
    input  logic                  es_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::alu_op_t   alu_op,
    output decode_pkg::word_t     alu_src1,
    output decode_pkg::word_t     alu_src2,
    output decode_pkg::word_t     rkd_value,
    output decode_pkg::word_t     ds_pc,
    output logic                  rf_we,
    output decode_pkg::reg_addr_t rf_waddr,
    output logic                  res_from_mem,
    output logic                  mem_we,
    // forwarding sources
    input  logic                  es_res_from_mem,
    input  logic                  es_rf_we,
    input  decode_pkg::reg_addr_t es_rf_waddr,
    input  decode_pkg::word_t     es_rf_wdata,
    input  logic                  ms_rf_we,
    input  decode_pkg::reg_addr_t ms_rf_waddr,
    input  decode_pkg::word_t     ms_rf_wdata,
    input  logic                  ws_rf_we,
    input  decode_pkg::reg_addr_t ws_rf_waddr,
    input  decode_pkg::word_t     ws_rf_wdata,
    // branch
    output logic                  br_taken,
    output decode_pkg::word_t     br_target
);
    import decode_pkg::*;

    logic  ds_valid;
    inst_t ds_inst;
    logic  stall;
    word_t rf_rdata1;
    word_t rf_rdata2;
    word_t rj_value;

    decode_if dec_bus ();

    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    // a taken branch squashes whatever fetch offers on the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_decoder (
        .inst (ds_inst),
        .dec  (dec_bus.decoder)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec_bus.rf_raddr1),
        .raddr2 (dec_bus.rf_raddr2),
        .waddr  (ws_rf_waddr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_rf_we),
        .wdata  (ws_rf_wdata)
    );

    operand_forward u_forward (
        .dec             (dec_bus.operand),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .pc              (ds_pc),
        .es_res_from_mem (es_res_from_mem),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_rf_wdata     (es_rf_wdata),
        .ms_rf_we        (ms_rf_we),
        .ms_rf_waddr     (ms_rf_waddr),
        .ms_rf_wdata     (ms_rf_wdata),
        .ws_rf_we        (ws_rf_we),
        .ws_rf_waddr     (ws_rf_waddr),
        .ws_rf_wdata     (ws_rf_wdata),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .stall           (stall)
    );

    // resolved only once the operands are final
    branch_unit u_branch (
        .dec       (dec_bus.branch),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (ds_pc),
        .valid     (ds_to_es_valid),
        .taken     (br_taken),
        .target    (br_target)
    );

    assign alu_op       = dec_bus.alu_op;
    assign rf_we        = dec_bus.rf_we;
    assign rf_waddr     = dec_bus.rf_waddr;
    assign res_from_mem = dec_bus.res_from_mem;
    assign mem_we       = dec_bus.mem_we;

    a_valid_source: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(ds_to_es_valid) |-> ds_valid
    ) else $error("ds_to_es_valid rose with an empty stage");

endmodule

// File: tests/tb_decode_stage.sv
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import decode_pkg::*;

    localparam int period  = 100;
    localparam int n_items = 300;

    logic      clk;
    logic      resetn;
    logic      fs_to_ds_valid;
    inst_t     fs_inst;
    word_t     fs_pc;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    alu_op_t   alu_op;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     rkd_value;
    word_t     ds_pc;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      res_from_mem;
    logic      mem_we;
    logic      es_res_from_mem;
    logic      es_rf_we, ms_rf_we, ws_rf_we;
    reg_addr_t es_rf_waddr, ms_rf_waddr, ws_rf_waddr;
    word_t     es_rf_wdata, ms_rf_wdata, ws_rf_wdata;
    logic      br_taken;
    word_t     br_target;

    // reference model state
    word_t     ref_rf [nreg];
    integer    seed;
    int        n_checks;
    int        n_errors;

    // expected decode and operands of the held instruction
    alu_op_t   exp_alu_op;
    logic      exp_src1_pc, exp_src2_imm, exp_need1, exp_need2;
    logic      exp_we, exp_from_mem, exp_mem_we, exp_stall, exp_taken;
    word_t     exp_imm, exp_rj, exp_rkd, exp_target;
    reg_addr_t exp_ra1, exp_ra2, exp_waddr;

    // fixed opcode bits, index is the instruction kind
    word_t base_table [30] = '{
        32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000,
        32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0040_8000, 32'h0044_8000,
        32'h0048_8000, 32'h0280_0000, 32'h0200_0000, 32'h0240_0000, 32'h0340_0000,
        32'h0380_0000, 32'h03c0_0000, 32'h1400_0000, 32'h1c00_0000, 32'h2880_0000,
        32'h2980_0000, 32'h4c00_0000, 32'h5000_0000, 32'h5400_0000, 32'h5800_0000,
        32'h5c00_0000, 32'h6000_0000, 32'h6400_0000, 32'h6800_0000, 32'h6c00_0000
    };

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        repeat (n_items * 20) @(posedge clk);
        $display("watchdog expired before all items were checked");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic word_t field_mask(input int kind);
        word_t m;
        if (kind <= 10) begin
            m = 32'h0000_7fff;
        end else if (kind == 17 || kind == 18) begin
            m = 32'h01ff_ffff;
        end else if (kind >= 21) begin
            m = 32'h03ff_ffff;
        end else begin
            m = 32'h003f_ffff;
        end
        return m;
    endfunction

    // forwarding model, newest stage first
    function automatic word_t fwd(input reg_addr_t a);
        word_t v;
        if (a == 5'd0) begin
            v = '0;
        end else if (es_rf_we && es_rf_waddr == a) begin
            v = es_rf_wdata;
        end else if (ms_rf_we && ms_rf_waddr == a) begin
            v = ms_rf_wdata;
        end else if (ws_rf_we && ws_rf_waddr == a) begin
            v = ws_rf_wdata;
        end else begin
            v = ref_rf[a];
        end
        return v;
    endfunction

    function automatic reg_addr_t pick_addr(input inst_t inst, input logic [1:0] sel,
                                            input reg_addr_t rnd);
        reg_addr_t a;
        case (sel)
            2'd0: a = inst[9:5];
            2'd1: a = inst[14:10];
            2'd2: a = inst[4:0];
            default: a = rnd;
        endcase
        return a;
    endfunction

    task automatic decode_ref(input int kind, input inst_t inst);
        exp_alu_op   = '0;
        exp_src1_pc  = (kind == 18 || kind == 21 || kind == 23);
        exp_src2_imm = 1'b1;
        exp_ra1      = inst[9:5];
        exp_ra2      = inst[14:10];
        exp_need1    = 1'b1;
        exp_need2    = 1'b0;
        exp_waddr    = (kind == 23) ? link_reg : inst[4:0];
        exp_we       = !(kind == 20 || kind == 22 || kind >= 24);
        exp_from_mem = (kind == 19);
        exp_mem_we   = (kind == 20);
        case (kind)
            0, 11, 18, 19, 20, 21, 23: exp_alu_op[alu_add] = 1'b1;
            1: exp_alu_op[alu_sub] = 1'b1;
            2, 12: exp_alu_op[alu_slt] = 1'b1;
            3, 13: exp_alu_op[alu_sltu] = 1'b1;
            4: exp_alu_op[alu_nor] = 1'b1;
            5, 14: exp_alu_op[alu_and] = 1'b1;
            6, 15: exp_alu_op[alu_or] = 1'b1;
            7, 16: exp_alu_op[alu_xor] = 1'b1;
            8: exp_alu_op[alu_sll] = 1'b1;
            9: exp_alu_op[alu_srl] = 1'b1;
            10: exp_alu_op[alu_sra] = 1'b1;
            17: exp_alu_op[alu_lui] = 1'b1;
            default: exp_alu_op = '0;
        endcase
        if (kind <= 7 || kind == 22 || kind >= 24) begin
            exp_src2_imm = 1'b0;
            exp_imm = '0;
        end else if (kind <= 10) begin
            exp_imm = {27'b0, inst[14:10]};
        end else if (kind <= 13 || kind == 19 || kind == 20) begin
            exp_imm = {{20{inst[21]}}, inst[21:10]};
        end else if (kind <= 16) begin
            exp_imm = {20'b0, inst[21:10]};
        end else if (kind <= 18) begin
            exp_imm = {inst[24:5], 12'b0};
        end else begin
            exp_imm = 32'd4;
        end
        // 3R, stores and compare branches need both sources
        exp_need2 = (kind <= 7 || kind == 20 || kind >= 24);
        if (kind == 17 || kind == 18 || kind == 22 || kind == 23) begin
            exp_need1 = 1'b0;
        end
        if (kind == 20 || kind >= 24) begin
            exp_ra2 = inst[4:0];
        end
    endtask

    task automatic predict(input int kind, input inst_t inst, input word_t pc);
        word_t offs16;
        word_t offs26;
        logic  cond;
        offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        decode_ref(kind, inst);
        exp_rj  = fwd(exp_ra1);
        exp_rkd = fwd(exp_ra2);
        // load result not ready while in execute
        exp_stall = es_res_from_mem && es_rf_we && (es_rf_waddr != 5'd0)
                    && ((exp_need1 && es_rf_waddr == exp_ra1)
                        || (exp_need2 && es_rf_waddr == exp_ra2));
        case (kind)
            21, 22, 23: cond = 1'b1;
            24: cond = (exp_rj == exp_rkd);
            25: cond = (exp_rj != exp_rkd);
            26: cond = ($signed(exp_rj) < $signed(exp_rkd));
            27: cond = ($signed(exp_rj) >= $signed(exp_rkd));
            28: cond = (exp_rj < exp_rkd);
            29: cond = (exp_rj >= exp_rkd);
            default: cond = 1'b0;
        endcase
        exp_taken = cond && !exp_stall;
        if (kind == 21) begin
            exp_target = exp_rj + offs16;
        end else if (kind == 22 || kind == 23) begin
            exp_target = pc + offs26;
        end else begin
            exp_target = pc + offs16;
        end
    endtask

    task automatic compare(input string test, input string what, input word_t exp,
                           input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("error %s %s: expected %h actual %h", test, what, exp, act);
        end
    endtask

    task automatic check_held(input word_t pc);
        string flow;
        if (exp_stall) begin
            flow = "load_use_stall";
        end else begin
            flow = "back_pressure";
        end
        compare(flow, "ds_to_es_valid", {31'b0, !exp_stall}, {31'b0, ds_to_es_valid});
        compare(flow, "ds_allowin", {31'b0, !exp_stall && es_allowin}, {31'b0, ds_allowin});
        compare("branch", "br_taken", {31'b0, exp_taken}, {31'b0, br_taken});
        if (!exp_stall) begin
            compare("alu_decode", "alu_op", {20'b0, exp_alu_op}, {20'b0, alu_op});
            compare("alu_decode", "rf_we", {31'b0, exp_we}, {31'b0, rf_we});
            compare("alu_decode", "rf_waddr", {27'b0, exp_waddr}, {27'b0, rf_waddr});
            compare("alu_decode", "res_from_mem", {31'b0, exp_from_mem}, {31'b0, res_from_mem});
            compare("alu_decode", "mem_we", {31'b0, exp_mem_we}, {31'b0, mem_we});
            compare("alu_decode", "ds_pc", pc, ds_pc);
            compare("forwarding", "alu_src1", exp_src1_pc ? pc : exp_rj, alu_src1);
            compare("forwarding", "alu_src2", exp_src2_imm ? exp_imm : exp_rkd, alu_src2);
            compare("forwarding", "rkd_value", exp_rkd, rkd_value);
        end
        if (exp_taken) begin
            compare("branch", "br_target", exp_target, br_target);
        end
    endtask

    task automatic check_empty(input string test);
        compare(test, "ds_to_es_valid", 32'd0, {31'b0, ds_to_es_valid});
        compare(test, "br_taken", 32'd0, {31'b0, br_taken});
        compare(test, "ds_allowin", 32'd1, {31'b0, ds_allowin});
    endtask

    task automatic drive_forwarding(input inst_t inst, input logic with_es_ms);
        word_t r;
        r = $random(seed);
        es_rf_we        = with_es_ms && r[0];
        es_res_from_mem = with_es_ms && r[1];
        ms_rf_we        = with_es_ms && r[2];
        ws_rf_we        = r[3];
        es_rf_waddr     = pick_addr(inst, r[5:4], r[14:10]);
        ms_rf_waddr     = pick_addr(inst, r[7:6], r[19:15]);
        ws_rf_waddr     = pick_addr(inst, r[9:8], r[24:20]);
        es_rf_wdata     = $random(seed);
        ms_rf_wdata     = $random(seed);
        ws_rf_wdata     = $random(seed);
    endtask

    // clock edge, then mirror the writeback into the model
    task automatic advance();
        @(posedge clk);
        if (ws_rf_we && ws_rf_waddr != 5'd0) begin
            ref_rf[ws_rf_waddr] = ws_rf_wdata;
        end
    endtask

    task automatic run_item();
        word_t r;
        int    kind;
        inst_t inst;
        word_t pc;
        logic  held;
        logic  taken;
        r    = $random(seed);
        kind = int'(r[7:0] % 8'd30);
        inst = base_table[kind] | ($random(seed) & field_mask(kind));
        pc   = $random(seed);
        pc[1:0] = 2'b00;

        @(negedge clk);
        fs_to_ds_valid = 1'b1;
        fs_inst        = inst;
        fs_pc          = pc;
        es_allowin     = 1'b1;
        drive_forwarding(inst, 1'b0);
        #(period / 4);
        compare("handshake", "ds_allowin", 32'd1, {31'b0, ds_allowin});
        advance();

        @(negedge clk);
        drive_forwarding(inst, 1'b1);
        r = $random(seed);
        es_allowin = (r[1:0] != 2'b00);
        predict(kind, inst, pc);
        held  = exp_stall || (!es_allowin && !exp_taken);
        taken = exp_taken;
        // offer a fetch only where it must be refused or dropped
        fs_to_ds_valid = !(es_allowin && !exp_stall && !exp_taken);
        fs_inst        = $random(seed);
        fs_pc          = pc + 32'h100;
        #(period / 4);
        check_held(pc);
        advance();

        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        es_allowin     = 1'b1;
        drive_forwarding(inst, 1'b0);
        #(period / 4);
        if (held) begin
            predict(kind, inst, pc);
            check_held(pc);
        end else if (taken) begin
            check_empty("branch");
        end else begin
            check_empty("handshake");
        end
        advance();
    endtask

    initial begin
        seed            = 32'haf63_aace;
        n_checks        = 0;
        n_errors        = 0;
        resetn          = 1'b0;
        fs_to_ds_valid  = 1'b0;
        fs_inst         = '0;
        fs_pc           = '0;
        es_allowin      = 1'b1;
        es_res_from_mem = 1'b0;
        es_rf_we        = 1'b0;
        ms_rf_we        = 1'b0;
        ws_rf_we        = 1'b0;
        es_rf_waddr     = '0;
        ms_rf_waddr     = '0;
        ws_rf_waddr     = '0;
        es_rf_wdata     = '0;
        ms_rf_wdata     = '0;
        ws_rf_wdata     = '0;
        for (int i = 0; i < nreg; i++) begin
            ref_rf[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #(period / 4);
        check_empty("reset");

        // regfile has no reset, so load every register first
        for (int i = 1; i < nreg; i++) begin
            @(negedge clk);
            ws_rf_we    = 1'b1;
            ws_rf_waddr = reg_addr_t'(i);
            ws_rf_wdata = $random(seed);
            advance();
        end

        for (int n = 0; n < n_items; n++) begin
            run_item();
        end

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
design/decode_pkg.sv
design/decode_if.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_forward.sv
design/branch_unit.sv
design/decode_stage.sv
tests/tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
